/* hw/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data path and instruction word width.
`define LEN_WORD 32

// Index width of the 32-entry register file.
`define LEN_REG_ADDR 5

// Data memory is 2**LEN_MEMDATA_ADDR bytes, sp starts at its top.
`define LEN_MEMDATA_ADDR 16

`define HEAP_POINTER_INIT 32'h0000_8000 // Reset value of gp.

`define LEN_AXI_ADDR 12

`endif

/* hw/rv_pkg.sv */
`include "rv_settings.svh"

package rv_pkg;

    typedef logic [`LEN_WORD-1:0]     word_t;
    typedef logic [`LEN_REG_ADDR-1:0] reg_addr_t;
    typedef logic [`LEN_AXI_ADDR-1:0] axi_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B  // Immediate straight through, for LUI.
    } alu_op_t;

    typedef enum logic {
        ST_IDLE,
        ST_RESP
    } axi_state_t;

endpackage

/* hw/regs.sv */
`timescale 1ns/1ns

`include "rv_settings.svh"

module regs (
    input  logic              clk,
    input  logic              rstn,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::reg_addr_t host_addr,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    output rv_pkg::word_t     host_data,
    input  logic              wr_en,
    input  rv_pkg::reg_addr_t rd_addr,
    input  rv_pkg::word_t     wr_data
);

    localparam int NUM_REGS = 2 ** `LEN_REG_ADDR;

    localparam rv_pkg::word_t SP_INIT = rv_pkg::word_t'(1) << `LEN_MEMDATA_ADDR;
    localparam rv_pkg::word_t GP_INIT = `HEAP_POINTER_INIT;

    rv_pkg::word_t regs_q [NUM_REGS];

    // x0 is hardwired.
    assign rs1_data  = (rs1_addr == '0) ? '0 : regs_q[rs1_addr];
    assign rs2_data  = (rs2_addr == '0) ? '0 : regs_q[rs2_addr];
    assign host_data = (host_addr == '0) ? '0 : regs_q[host_addr];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                case (i)
                    2:       regs_q[i] <= SP_INIT;  // sp.
                    3:       regs_q[i] <= GP_INIT;  // gp.
                    default: regs_q[i] <= '0;
                endcase
            end
        end else if (wr_en && rd_addr != '0) begin
            regs_q[rd_addr] <= wr_data;
        end
    end

endmodule

/* hw/decoder.sv */
`timescale 1ns/1ns

module decoder (
    input  rv_pkg::word_t     instr,
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::reg_addr_t rd_addr,
    output rv_pkg::word_t     imm,
    output logic              use_imm,
    output rv_pkg::alu_op_t   alu_op,
    output logic              legal
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            f7_zero;
    logic            f7_alt;
    rv_pkg::alu_op_t f3_op;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);  // Selects SUB and SRA.

    always_comb begin
        case (funct3)
            3'b000:  f3_op = rv_pkg::ALU_ADD;
            3'b001:  f3_op = rv_pkg::ALU_SLL;
            3'b010:  f3_op = rv_pkg::ALU_SLT;
            3'b011:  f3_op = rv_pkg::ALU_SLTU;
            3'b100:  f3_op = rv_pkg::ALU_XOR;
            3'b101:  f3_op = rv_pkg::ALU_SRL;
            3'b110:  f3_op = rv_pkg::ALU_OR;
            default: f3_op = rv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        rs1_addr = instr[19:15];
        rs2_addr = instr[24:20];
        rd_addr  = instr[11:7];
        imm      = {{20{instr[31]}}, instr[31:20]};  // I-type, sign extended.
        use_imm  = 1'b0;
        alu_op   = f3_op;
        case (opcode)
            OPC_OP: begin
                if (f7_alt && funct3 == 3'b000) begin
                    alu_op = rv_pkg::ALU_SUB;
                end else if (f7_alt && funct3 == 3'b101) begin
                    alu_op = rv_pkg::ALU_SRA;
                end
                legal = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                if (f7_alt && funct3 == 3'b101) begin
                    alu_op = rv_pkg::ALU_SRA;
                end
                // Only the shifts constrain the upper immediate bits.
                if (funct3 == 3'b001) begin
                    legal = f7_zero;
                end else if (funct3 == 3'b101) begin
                    legal = f7_zero || f7_alt;
                end else begin
                    legal = 1'b1;
                end
            end
            OPC_LUI: begin
                rs1_addr = '0;
                imm      = {instr[31:12], 12'b0};
                use_imm  = 1'b1;
                alu_op   = rv_pkg::ALU_PASS_B;
                legal    = 1'b1;
            end
            default: legal = 1'b0;  // Loads, stores, branches and the rest.
        endcase
    end

endmodule

/* hw/alu.sv */
`timescale 1ns/1ns

module alu (
    input  rv_pkg::alu_op_t op,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    output rv_pkg::word_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        result = '0;
        case (op)
            rv_pkg::ALU_ADD:    result = a + b;
            rv_pkg::ALU_SUB:    result = a - b;
            rv_pkg::ALU_AND:    result = a & b;
            rv_pkg::ALU_OR:     result = a | b;
            rv_pkg::ALU_XOR:    result = a ^ b;
            rv_pkg::ALU_SLL:    result = a << shamt;
            rv_pkg::ALU_SRL:    result = a >> shamt;
            rv_pkg::ALU_SRA: begin
                result = rv_pkg::word_t'($signed(a) >>> shamt);
            end
            rv_pkg::ALU_SLT: begin
                result[0] = $signed(a) < $signed(b);
            end
            rv_pkg::ALU_SLTU: begin
                result[0] = a < b;
            end
            rv_pkg::ALU_PASS_B: result = b;
            default:            result = '0;
        endcase
    end

endmodule

/* hw/exec_axil.sv */
`timescale 1ns/1ns

`include "rv_settings.svh"

module exec_axil (
    input  logic                    clk,
    input  logic                    rstn,
    input  rv_pkg::axi_addr_t       awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  rv_pkg::word_t           wdata,
    input  logic [`LEN_WORD/8-1:0]  wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  rv_pkg::axi_addr_t       araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output rv_pkg::word_t           rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,
    output rv_pkg::word_t           instr,
    input  logic                    legal,
    output logic                    wr_en,
    output rv_pkg::reg_addr_t       host_addr,
    input  rv_pkg::word_t           host_data
);

    localparam logic [1:0]        RESP_OKAY   = 2'b00;
    localparam logic [1:0]        RESP_SLVERR = 2'b10;
    localparam rv_pkg::axi_addr_t INSTR_ADDR  = 'h000;
    localparam rv_pkg::axi_addr_t REG_BASE    = 'h400;
    localparam int                IDX_LSB     = 2;
    localparam int                IDX_MSB     = `LEN_REG_ADDR + IDX_LSB - 1;

    rv_pkg::axi_state_t      state_q;
    logic                    w_ready_q;
    logic                    first_q;
    rv_pkg::axi_addr_t       awaddr_q;
    logic [`LEN_WORD/8-1:0]  wstrb_q;
    rv_pkg::word_t           instr_q;
    logic                    commit;
    logic                    ar_ready_q;
    logic                    rvalid_q;
    rv_pkg::word_t           rdata_q;
    logic [1:0]              rresp_q;
    logic                    reg_hit;

    assign awready = w_ready_q;
    assign wready  = w_ready_q;
    assign bvalid  = (state_q == rv_pkg::ST_RESP);
    assign instr   = instr_q;

    // Latched request is good and the decoder accepts it.
    assign commit = (awaddr_q == INSTR_ADDR) && (&wstrb_q) && legal;
    assign bresp  = commit ? RESP_OKAY : RESP_SLVERR;
    assign wr_en  = first_q && commit;  // First response cycle only.

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q   <= rv_pkg::ST_IDLE;
            w_ready_q <= 1'b0;
            first_q   <= 1'b0;
        end else begin
            first_q <= 1'b0;
            case (state_q)
                rv_pkg::ST_IDLE: begin
                    if (w_ready_q && awvalid && wvalid) begin
                        state_q   <= rv_pkg::ST_RESP;
                        w_ready_q <= 1'b0;
                        first_q   <= 1'b1;
                    end else begin
                        w_ready_q <= 1'b1;
                    end
                end
                default: begin
                    if (bready) begin
                        state_q   <= rv_pkg::ST_IDLE;
                        w_ready_q <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == rv_pkg::ST_IDLE && w_ready_q && awvalid && wvalid) begin
            awaddr_q <= awaddr;
            wstrb_q  <= wstrb;
            instr_q  <= wdata;
        end
    end

    // Register window is 0x400 to 0x47C, word aligned.
    assign reg_hit = (araddr[`LEN_AXI_ADDR-1:IDX_MSB+1] == REG_BASE[`LEN_AXI_ADDR-1:IDX_MSB+1])
                     && (araddr[IDX_LSB-1:0] == '0);
    assign host_addr = araddr[IDX_MSB:IDX_LSB];

    assign arready = ar_ready_q;
    assign rvalid  = rvalid_q;
    assign rdata   = rdata_q;
    assign rresp   = rresp_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ar_ready_q <= 1'b0;
            rvalid_q   <= 1'b0;
        end else if (ar_ready_q && arvalid) begin
            ar_ready_q <= 1'b0;
            rvalid_q   <= 1'b1;
        end else if (rvalid_q && rready) begin
            ar_ready_q <= 1'b1;
            rvalid_q   <= 1'b0;
        end else if (!rvalid_q) begin
            ar_ready_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_ready_q && arvalid) begin
            rdata_q <= reg_hit ? host_data : '0;  // Pre-write value on a collision.
            rresp_q <= reg_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

/* hw/exec_top.sv */
`timescale 1ns/1ns

`include "rv_settings.svh"

module exec_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  rv_pkg::axi_addr_t      awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  rv_pkg::word_t          wdata,
    input  logic [`LEN_WORD/8-1:0] wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  rv_pkg::axi_addr_t      araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output rv_pkg::word_t          rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready
);

    rv_pkg::word_t     instr;
    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::reg_addr_t rs2_addr;
    rv_pkg::reg_addr_t rd_addr;
    rv_pkg::reg_addr_t host_addr;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;
    rv_pkg::word_t     host_data;
    rv_pkg::word_t     imm;
    rv_pkg::word_t     alu_b;
    rv_pkg::word_t     wr_data;
    rv_pkg::alu_op_t   alu_op;
    logic              use_imm;
    logic              legal;
    logic              wr_en;

    assign alu_b = use_imm ? imm : rs2_data;  // Operand B select.

    exec_axil i_axil (
        .clk       (clk),
        .rstn      (rstn),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .instr     (instr),
        .legal     (legal),
        .wr_en     (wr_en),
        .host_addr (host_addr),
        .host_data (host_data)
    );

    decoder i_decoder (
        .instr    (instr),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .imm      (imm),
        .use_imm  (use_imm),
        .alu_op   (alu_op),
        .legal    (legal)
    );

    regs i_regs (
        .clk       (clk),
        .rstn      (rstn),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .host_addr (host_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .host_data (host_data),
        .wr_en     (wr_en),
        .rd_addr   (rd_addr),
        .wr_data   (wr_data)
    );

    alu i_alu (
        .op     (alu_op),
        .a      (rs1_data),
        .b      (alu_b),
        .result (wr_data)
    );

endmodule

/* bench/exec_asserts.sv */
`timescale 1ns/1ns

module exec_asserts (
    input logic          clk,
    input logic          rstn,
    input logic          awvalid,
    input logic          awready,
    input logic          wvalid,
    input logic          wready,
    input logic [1:0]    bresp,
    input logic          bvalid,
    input logic          bready,
    input logic          arvalid,
    input logic          arready,
    input rv_pkg::word_t rdata,
    input logic [1:0]    rresp,
    input logic          rvalid,
    input logic          rready
);

    int fail_count = 0;  // Assertion failures so far.

    b_hold: assert property (@(posedge clk) disable iff (!rstn)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            fail_count++;
            $error("Write response dropped or changed before bready.");
        end

    r_hold: assert property (@(posedge clk) disable iff (!rstn)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            fail_count++;
            $error("Read response dropped or changed before rready.");
        end

    b_latency: assert property (@(posedge clk) disable iff (!rstn)
        awvalid && awready && wvalid && wready |=> bvalid)
        else begin
            fail_count++;
            $error("bvalid missing one cycle after the write transfer.");
        end

    r_latency: assert property (@(posedge clk) disable iff (!rstn)
        arvalid && arready |=> rvalid)
        else begin
            fail_count++;
            $error("rvalid missing one cycle after the read transfer.");
        end

    // Handshake outputs clear on the first reset edge.
    reset_quiet: assert property (@(posedge clk)
        !rstn |=> !awready && !wready && !arready && !bvalid && !rvalid)
        else begin
            fail_count++;
            $error("Handshake output high during reset.");
        end

endmodule

bind exec_top exec_asserts i_asserts (.*);

/* bench/exec_tb.sv */
`timescale 1ns/1ns

`include "rv_settings.svh"

module exec_tb;

    localparam rv_pkg::axi_addr_t INSTR_ADDR = 12'h000;
    localparam logic [1:0]        OKAY       = 2'b00;
    localparam logic [1:0]        SLVERR     = 2'b10;
    localparam int                TIMEOUT    = 100;

    logic              clk;
    logic              rstn;
    rv_pkg::axi_addr_t awaddr;
    logic              awvalid;
    logic              awready;
    rv_pkg::word_t     wdata;
    logic [3:0]        wstrb;
    logic              wvalid;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              bready;
    rv_pkg::axi_addr_t araddr;
    logic              arvalid;
    logic              arready;
    rv_pkg::word_t     rdata;
    logic [1:0]        rresp;
    logic              rvalid;
    logic              rready;

    logic [31:0] model [32];  // Expected register file.
    int          max_hold;    // Upper bound of bready and rready stalls.

    exec_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Bound protocol checker on the DUT.
    always @(i_dut.i_asserts.fail_count) begin
        if (i_dut.i_asserts.fail_count != 0) begin
            $display("Testbench failed");
            $display("A protocol assertion on the DUT ports did not hold.");
            $fatal(1);
        end
    end

    task automatic timeout_fail(input string what);
        $display("Testbench failed");
        $display("Timeout while waiting for %s.", what);
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Testbench failed");
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            $fatal(1);
        end
    endtask

    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = $urandom();
        return r[4:0];
    endfunction

    // RV32I result for funct3 with alt selecting SUB and SRA.
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, sa < sb};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt) begin
                    return sa >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic axi_write(input rv_pkg::axi_addr_t addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int n;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        while (!(awready && wready)) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) timeout_fail("awready and wready");
        end
        @(negedge clk);  // Transfer took place on the edge before.
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat ($urandom_range(max_hold, 0)) @(negedge clk);
        n = 0;
        while (!bvalid) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) timeout_fail("bvalid");
        end
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input rv_pkg::axi_addr_t addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) timeout_fail("arready");
        end
        @(negedge clk);
        arvalid = 1'b0;
        repeat ($urandom_range(max_hold, 0)) @(negedge clk);
        n = 0;
        while (!rvalid) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) timeout_fail("rvalid");
        end
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic check_reg(input string name, input logic [4:0] n);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read({5'b01000, n, 2'b00}, data, resp);  // 0x400 + 4n.
        check_val({name, " rresp"}, {30'b0, OKAY}, {30'b0, resp});
        check_val(name, model[n], data);
    endtask

    task automatic check_all(input string name);
        for (int i = 0; i < 32; i++) begin
            check_reg(name, 5'(i));
        end
    endtask

    task automatic issue(input string name, input logic [31:0] instr, input logic [1:0] exp);
        logic [1:0] resp;
        axi_write(INSTR_ADDR, instr, 4'hf, resp);
        check_val({name, " bresp"}, {30'b0, exp}, {30'b0, resp});
    endtask

    task automatic run_r(input string name, input logic [2:0] f3, input logic alt,
                         input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd);
        logic [31:0] exp;
        exp = alu_ref(f3, alt, model[rs1], model[rs2]);
        issue(name, {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011}, OKAY);
        if (rd != 5'd0) model[rd] = exp;
        check_reg(name, rd);
    endtask

    task automatic run_i(input string name, input logic [2:0] f3, input logic [11:0] imm,
                         input logic [4:0] rs1, input logic [4:0] rd);
        logic [31:0] exp;
        exp = alu_ref(f3, (f3 == 3'd5) && imm[10], model[rs1], {{20{imm[11]}}, imm});
        issue(name, {imm, rs1, f3, rd, 7'b0010011}, OKAY);
        if (rd != 5'd0) model[rd] = exp;
        check_reg(name, rd);
    endtask

    task automatic run_lui(input string name, input logic [4:0] rd, input logic [19:0] imm);
        issue(name, {imm, rd, 7'b0110111}, OKAY);
        if (rd != 5'd0) model[rd] = {imm, 12'b0};
        check_reg(name, rd);
    endtask

    initial begin
        logic [1:0]  resp;
        logic [31:0] data;
        logic [31:0] r;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [4:0]  sh;
        logic [31:0] addi;
        void'($urandom(12));
        rstn     = 1'b0;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        max_hold = 0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        model[2] = 32'd1 << `LEN_MEMDATA_ADDR;
        model[3] = `HEAP_POINTER_INIT;
        repeat (5) @(negedge clk);
        rstn = 1'b1;

        check_all("reset");

        for (int i = 1; i < 32; i++) begin
            r = $urandom();
            run_lui("load", 5'(i), r[31:12]);
            run_i("load", 3'd6, r[11:0], 5'(i), 5'(i));
        end
        for (int k = 0; k < 10; k++) begin
            f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);  // Then SUB and SRA.
            repeat (3) run_r("r_type", f3, k >= 8, rand_reg(), rand_reg(), rand_reg());
        end

        foreach (model[k]) begin
            if (k < 8 && k != 1 && k != 5) begin
                r = $urandom();
                run_i("i_type", 3'(k), r[11:0], rand_reg(), rand_reg());
                run_i("i_type_neg", 3'(k), {1'b1, r[22:12]}, rand_reg(), rand_reg());
            end
        end
        for (int k = 0; k < 3; k++) begin
            sh = (k == 0) ? 5'd0 : ((k == 1) ? 5'd31 : rand_reg());
            run_i("slli", 3'd1, {7'b0, sh}, rand_reg(), rand_reg());
            run_i("srli", 3'd5, {7'b0, sh}, rand_reg(), rand_reg());
            run_i("srai", 3'd5, {7'b0100000, sh}, rand_reg(), rand_reg());
            r = $urandom();
            run_lui("lui", rand_reg(), r[19:0]);
        end

        run_r("rd_zero", 3'd0, 1'b0, rand_reg(), rand_reg(), 5'd0);
        run_r("x0_source", 3'd6, 1'b0, 5'd0, 5'd7, 5'd9);
        run_i("x0_source", 3'd0, 12'h123, 5'd0, 5'd10);

        addi = {12'd1, 5'd0, 3'd0, 5'd1, 7'b0010011};  // addi x1, x0, 1.
        axi_write(12'h004, addi, 4'hf, resp);
        check_val("bad_addr", {30'b0, SLVERR}, {30'b0, resp});
        axi_write(INSTR_ADDR, addi, 4'b0111, resp);
        check_val("partial_strobe", {30'b0, SLVERR}, {30'b0, resp});
        issue("store", {7'b0, 5'd1, 5'd2, 3'b010, 5'd4, 7'b0100011}, SLVERR);
        issue("branch", {7'b0, 5'd1, 5'd2, 3'b000, 5'd4, 7'b1100011}, SLVERR);
        check_all("after_errors");
        axi_read(12'h800, data, resp);
        check_val("bad_read rresp", {30'b0, SLVERR}, {30'b0, resp});
        check_val("bad_read rdata", 32'd0, data);

        max_hold = 6;
        repeat (40) begin
            r  = $urandom();
            f3 = r[3:1];
            if (r[0]) begin
                run_r("backpressure", f3, r[4] && (f3 == 3'd0 || f3 == 3'd5),
                      rand_reg(), rand_reg(), rand_reg());
            end else begin
                imm = r[31:20];
                if (f3 == 3'd1) imm[11:5] = 7'b0;
                if (f3 == 3'd5) imm[11:5] = {1'b0, r[4], 5'b0};
                run_i("backpressure", f3, imm, rand_reg(), rand_reg());
            end
        end
        check_all("backpressure");

        $display("Testbench passed");
        $finish;
    end

endmodule

/* list.f */
+incdir+hw
hw/rv_pkg.sv
hw/regs.sv
hw/decoder.sv
hw/alu.sv
hw/exec_axil.sv
hw/exec_top.sv
bench/exec_asserts.sv
bench/exec_tb.sv

/* Makefile */
# Verilator build and run of the execution unit testbench.

VERILATOR ?= verilator
TOP       ?= exec_tb
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

SRCS := $(wildcard hw/*.sv hw/*.svh bench/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes.
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$($(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
